// File: hdl/dcache_macros.svh
//////////////////////////////
// dcache sizes
// two ways, 64 sets, one 64-bit word per line.
//////////////////////////////
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DC_ADDR_W   32 // byte address.
`define DC_DATA_W   64 // line and word.
`define DC_STRB_W   8  // one strobe per byte.
`define DC_OFFSET_W 3
`define DC_INDEX_W  6
`define DC_SETS     64

// tag is what is left above index and offset.
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// File: hdl/dcache_pkg.sv
//////////////////////////////
// dcache types
// controller states, memory commands and the request and tag records.
//////////////////////////////
`include "dcache_macros.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_HIT       = 3'd2,
        ST_WRITEBACK = 3'd3,
        ST_REFILL    = 3'd4,
        ST_REREAD    = 3'd5  // wait for the refilled set to read back.
    } dc_state_e;

    typedef enum logic [1:0] {
        MEM_NONE      = 2'd0,
        MEM_WRITEBACK = 2'd1,
        MEM_REFILL    = 2'd2
    } mem_cmd_e;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic [`DC_STRB_W-1:0] strb;
        logic                  write; // store when set.
    } cpu_req_t;

    typedef struct packed {
        mem_cmd_e              cmd;
        logic [`DC_ADDR_W-1:0] addr;  // line aligned.
        logic [`DC_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

// File: hdl/dcache_tag_array.sv
//////////////////////////////
// dcache tag array
// tag, valid and dirty per way and set, registered read.
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [`DC_INDEX_W-1:0]       index_i,
    input  logic [1:0]                   we_i,
    input  dcache_pkg::tag_entry_t       wdata_i,
    output dcache_pkg::tag_entry_t [1:0] rdata_o
);

    logic [`DC_TAG_W-1:0]     tag_mem [2][`DC_SETS];
    logic [1:0][`DC_SETS-1:0] valid_q;
    logic [1:0][`DC_SETS-1:0] dirty_q;

    ////////////////////////////// state bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    valid_q[w][index_i] <= wdata_i.valid;
                    dirty_q[w][index_i] <= wdata_i.dirty;
                end
            end
        end
    end

    ////////////////////////////// tags and read port
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we_i[w]) begin
                tag_mem[w][index_i] <= wdata_i.tag;
            end
            rdata_o[w].valid <= valid_q[w][index_i]; // old value on a same-cycle write.
            rdata_o[w].dirty <= dirty_q[w][index_i];
            rdata_o[w].tag   <= tag_mem[w][index_i];
        end
    end

endmodule

// File: hdl/dcache_data_array.sv
//////////////////////////////
// dcache data array
// one line per way and set, byte write enables, registered read.
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                          clk,
    input  logic [`DC_INDEX_W-1:0]        index_i,
    input  logic [1:0][`DC_STRB_W-1:0]    strb_i,
    input  logic [`DC_DATA_W-1:0]         wdata_i,
    output logic [1:0][`DC_DATA_W-1:0]    rdata_o
);

    logic [`DC_STRB_W-1:0][7:0] line_mem [2][`DC_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (strb_i[w][b]) begin
                    line_mem[w][index_i][b] <= wdata_i[b*8 +: 8];
                end
            end
            rdata_o[w] <= line_mem[w][index_i]; // read before write.
        end
    end

endmodule

// File: hdl/dcache_ctrl.sv
//////////////////////////////
// dcache controller
// one FSM for loads and stores. looks up both ways, writes back a
// dirty victim, refills the line and re-reads the set.
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         cpu_valid_i,
    input  dcache_pkg::cpu_req_t         cpu_req_i,
    output logic                         cpu_ready_o,
    output logic                         cpu_done_o,
    output logic [`DC_DATA_W-1:0]        cpu_rdata_o,
    output dcache_pkg::mem_req_t         mem_req_o,
    input  logic                         mem_ack_i,
    input  logic [`DC_DATA_W-1:0]        mem_rdata_i,
    output logic [`DC_INDEX_W-1:0]       array_index_o,
    output logic [1:0]                   tag_we_o,
    output dcache_pkg::tag_entry_t       tag_wdata_o,
    input  dcache_pkg::tag_entry_t [1:0] tag_rdata_i,
    output logic [1:0][`DC_STRB_W-1:0]   data_strb_o,
    output logic [`DC_DATA_W-1:0]        data_wdata_o,
    input  logic [1:0][`DC_DATA_W-1:0]   data_rdata_i
);
    import dcache_pkg::*;

    localparam int IDX_LO = `DC_OFFSET_W;
    localparam int TAG_LO = `DC_OFFSET_W + `DC_INDEX_W;

    dc_state_e             state_q;
    dc_state_e             state_d;
    cpu_req_t              req_q;
    logic                  hit_way_q;
    logic                  victim_q;
    logic [`DC_SETS-1:0]   lru_q;     // names the way to evict next.
    mem_cmd_e              mem_cmd_q;
    logic [`DC_ADDR_W-1:0] mem_addr_q;
    logic [`DC_DATA_W-1:0] mem_wdata_q;

    logic                   accept;
    logic [`DC_INDEX_W-1:0] req_index;
    logic [`DC_TAG_W-1:0]   req_tag;
    logic [1:0]             way_hit;
    logic                   victim_d;
    logic                   victim_dirty;
    logic [`DC_ADDR_W-1:0]  wb_addr;
    logic [`DC_ADDR_W-1:0]  refill_addr;

    assign cpu_ready_o = (state_q == ST_IDLE);
    assign cpu_done_o  = (state_q == ST_HIT);
    assign cpu_rdata_o = data_rdata_i[hit_way_q];
    assign accept      = cpu_valid_i && cpu_ready_o;

    assign req_index = req_q.addr[TAG_LO-1:IDX_LO];
    assign req_tag   = req_q.addr[`DC_ADDR_W-1:TAG_LO];

    // the arrays see the incoming index while idle.
    assign array_index_o = (state_q == ST_IDLE) ? cpu_req_i.addr[TAG_LO-1:IDX_LO] : req_index;

    ////////////////////////////// lookup
    assign way_hit[0] = tag_rdata_i[0].valid && (tag_rdata_i[0].tag == req_tag);
    assign way_hit[1] = tag_rdata_i[1].valid && (tag_rdata_i[1].tag == req_tag);

    always_comb begin
        if (!tag_rdata_i[0].valid) begin
            victim_d = 1'b0;
        end else if (!tag_rdata_i[1].valid) begin
            victim_d = 1'b1;
        end else begin
            victim_d = lru_q[req_index];
        end
    end

    assign victim_dirty = tag_rdata_i[victim_d].valid && tag_rdata_i[victim_d].dirty;
    assign wb_addr      = {tag_rdata_i[victim_d].tag, req_index, {`DC_OFFSET_W{1'b0}}};
    assign refill_addr  = {req_q.addr[`DC_ADDR_W-1:IDX_LO], {`DC_OFFSET_W{1'b0}}};

    ////////////////////////////// FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (|way_hit) begin
                    state_d = ST_HIT;
                end else if (victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_HIT:       state_d = ST_IDLE;
            ST_WRITEBACK: state_d = mem_ack_i ? ST_REFILL : ST_WRITEBACK;
            ST_REFILL:    state_d = mem_ack_i ? ST_REREAD : ST_REFILL;
            ST_REREAD:    state_d = ST_LOOKUP;
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_HIT) begin
                lru_q[req_index] <= ~hit_way_q; // the other way ages.
            end
        end
    end

    ////////////////////////////// memory request
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_cmd_q <= MEM_NONE;
        end else if (state_q == ST_LOOKUP && !(|way_hit)) begin
            mem_cmd_q <= victim_dirty ? MEM_WRITEBACK : MEM_REFILL;
        end else if (mem_ack_i && state_q == ST_WRITEBACK) begin
            mem_cmd_q <= MEM_REFILL;
        end else if (mem_ack_i && state_q == ST_REFILL) begin
            mem_cmd_q <= MEM_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
        if (state_q == ST_LOOKUP) begin
            hit_way_q   <= way_hit[1];
            victim_q    <= victim_d;
            mem_addr_q  <= victim_dirty ? wb_addr : refill_addr;
            mem_wdata_q <= data_rdata_i[victim_d];
        end
        if (state_q == ST_WRITEBACK && mem_ack_i) begin
            mem_addr_q <= refill_addr;
        end
    end

    assign mem_req_o = '{cmd: mem_cmd_q, addr: mem_addr_q, wdata: mem_wdata_q};

    ////////////////////////////// array writes
    always_comb begin
        tag_we_o     = '0;
        tag_wdata_o  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
        data_strb_o  = '0;
        data_wdata_o = req_q.wdata;
        if (state_q == ST_HIT && req_q.write) begin
            tag_we_o[hit_way_q]    = 1'b1;
            tag_wdata_o.dirty      = 1'b1;
            data_strb_o[hit_way_q] = req_q.strb;
        end else if (state_q == ST_REFILL && mem_ack_i) begin
            tag_we_o[victim_q]    = 1'b1;   // clean line.
            data_strb_o[victim_q] = '1;
            data_wdata_o          = mem_rdata_i;
        end
    end

endmodule

// File: hdl/dcache_top.sv
//////////////////////////////
// dcache top
// two-way write-back data cache: controller, tag array, data array.
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  cpu_valid_i,
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  cpu_ready_o,
    output logic                  cpu_done_o,
    output logic [`DC_DATA_W-1:0] cpu_rdata_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  logic                  mem_ack_i,
    input  logic [`DC_DATA_W-1:0] mem_rdata_i
);
    import dcache_pkg::*;

    logic [`DC_INDEX_W-1:0]       array_index;
    logic [1:0]                   tag_we;
    tag_entry_t                   tag_wdata;
    tag_entry_t [1:0]             tag_rdata;
    logic [1:0][`DC_STRB_W-1:0]   data_strb;
    logic [`DC_DATA_W-1:0]        data_wdata;
    logic [1:0][`DC_DATA_W-1:0]   data_rdata;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cpu_valid_i   (cpu_valid_i),
        .cpu_req_i     (cpu_req_i),
        .cpu_ready_o   (cpu_ready_o),
        .cpu_done_o    (cpu_done_o),
        .cpu_rdata_o   (cpu_rdata_o),
        .mem_req_o     (mem_req_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .array_index_o (array_index),
        .tag_we_o      (tag_we),
        .tag_wdata_o   (tag_wdata),
        .tag_rdata_i   (tag_rdata),
        .data_strb_o   (data_strb),
        .data_wdata_o  (data_wdata),
        .data_rdata_i  (data_rdata)
    );

    dcache_tag_array u_tags (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .index_i (array_index),
        .we_i    (tag_we),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    dcache_data_array u_data (
        .clk     (clk),
        .index_i (array_index),
        .strb_i  (data_strb),
        .wdata_i (data_wdata),
        .rdata_o (data_rdata)
    );

endmodule

// File: sim/dcache_assert.sv
//////////////////////////////
// dcache protocol checks
// memory request hold, done pulse and ready level.
//////////////////////////////
`timescale 1ns/1ps

module dcache_assert (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 cpu_valid_i,
    input logic                 cpu_ready_o,
    input logic                 cpu_done_o,
    input dcache_pkg::mem_req_t mem_req_o,
    input logic                 mem_ack_i
);
    import dcache_pkg::*;

    int fail_cnt = 0; // failed assertions so far.

    mem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_req_o.cmd != MEM_NONE && !mem_ack_i) |=> $stable(mem_req_o))
        else begin
            fail_cnt++;
            $error("memory request changed before its acknowledge");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_done_o |=> !cpu_done_o)
        else begin
            fail_cnt++;
            $error("cpu_done_o high for two cycles");
        end

    // busy from acceptance, through every miss state, until done.
    busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
        (cpu_valid_i && cpu_ready_o) |=> !cpu_ready_o)
        else begin
            fail_cnt++;
            $error("cpu_ready_o high right after acceptance");
        end

    busy_until_done: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!cpu_ready_o && !cpu_done_o) |=> !cpu_ready_o)
        else begin
            fail_cnt++;
            $error("cpu_ready_o rose before cpu_done_o");
        end

endmodule

bind dcache_top dcache_assert u_assert (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cpu_valid_i (cpu_valid_i),
    .cpu_ready_o (cpu_ready_o),
    .cpu_done_o  (cpu_done_o),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i)
);

// File: sim/tb_dcache.sv
//////////////////////////////
// dcache testbench
// memory model, flat reference model, directed and random
// loads and stores against the cache.
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int MAX_CYCLES = 10000; // 300 random ops at ~25 cycles, directed ops, margin.

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  cpu_valid_i;
    cpu_req_t              cpu_req_i;
    logic                  cpu_ready_o;
    logic                  cpu_done_o;
    logic [`DC_DATA_W-1:0] cpu_rdata_o;
    mem_req_t              mem_req_o;
    logic                  mem_ack_i;
    logic [`DC_DATA_W-1:0] mem_rdata_i;

    integer                seed = 32'hc1f7b8ef;
    int                    err_cnt = 0;
    int                    cycles = 0;
    int                    lat;
    logic [`DC_DATA_W-1:0] mem_lines [logic [`DC_ADDR_W-1:0]];
    logic [`DC_DATA_W-1:0] ref_lines [logic [`DC_ADDR_W-1:0]]; // every store merged.
    mem_req_t              mem_log [$];                        // acknowledged transfers.

    dcache_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cpu_valid_i (cpu_valid_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_ready_o (cpu_ready_o),
        .cpu_done_o  (cpu_done_o),
        .cpu_rdata_o (cpu_rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [`DC_ADDR_W-1:0] line_addr(input logic [`DC_ADDR_W-1:0] addr);
        return {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    endfunction

    // power-up memory content differs for every line address.
    function automatic logic [`DC_DATA_W-1:0] fill_line(input logic [`DC_ADDR_W-1:0] la);
        return {la ^ 32'h5a5a_a5a5, ~la};
    endfunction

    function automatic logic [`DC_DATA_W-1:0] expected_line(input logic [`DC_ADDR_W-1:0] addr);
        logic [`DC_ADDR_W-1:0] la;
        la = line_addr(addr);
        return ref_lines.exists(la) ? ref_lines[la] : fill_line(la);
    endfunction

    task automatic merge_store(input logic [`DC_ADDR_W-1:0] addr,
                               input logic [`DC_DATA_W-1:0] wdata,
                               input logic [`DC_STRB_W-1:0] strb);
        logic [`DC_DATA_W-1:0] line;
        line = expected_line(addr);
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (strb[b]) begin
                line[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        ref_lines[line_addr(addr)] = line;
    endtask

    ////////////////////////////// memory model
    initial begin : memory_model
        int                    delay;
        logic [`DC_ADDR_W-1:0] la;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req_o.cmd != MEM_NONE) begin
                delay = $unsigned($random(seed)) % 4; // 0 to 3 wait cycles.
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                la = mem_req_o.addr;
                mem_log.push_back(mem_req_o);
                if (mem_req_o.cmd == MEM_WRITEBACK) begin
                    mem_lines[la] = mem_req_o.wdata;
                end else begin
                    mem_rdata_i = mem_lines.exists(la) ? mem_lines[la] : fill_line(la);
                end
                mem_ack_i = 1'b1;
                @(posedge clk);
                #1;
                mem_ack_i = 1'b0;
            end
        end
    end

    // runs one request from acceptance to done and counts its cycles in lat.
    task automatic access(input logic                  wr,
                          input logic [`DC_ADDR_W-1:0] addr,
                          input logic [`DC_DATA_W-1:0] wdata,
                          input logic [`DC_STRB_W-1:0] strb);
        logic [`DC_DATA_W-1:0] exp;
        while (!cpu_ready_o) begin
            @(posedge clk);
            #1;
        end
        cpu_valid_i = 1'b1;
        cpu_req_i   = '{addr: addr, wdata: wdata, strb: strb, write: wr};
        @(posedge clk);
        #1;
        cpu_valid_i = 1'b0;
        lat = 1;
        while (!cpu_done_o) begin
            @(posedge clk);
            #1;
            lat++;
        end
        if (wr) begin
            merge_store(addr, wdata, strb);
        end else begin
            exp = expected_line(addr);
            assert (cpu_rdata_o == exp) else begin
                err_cnt++;
                $display("Error at time %0d ns: cpu_rdata_o expected %h got %h",
                         $time, exp, cpu_rdata_o);
            end
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////// stimulus
    initial begin : stimulus
        logic [`DC_ADDR_W-1:0] a_addr;
        logic [`DC_ADDR_W-1:0] l1;
        logic [`DC_ADDR_W-1:0] l2;
        logic [`DC_ADDR_W-1:0] l3;
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]           rnd;
        logic [`DC_DATA_W-1:0] wd;
        rst_n_i     = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_req_i   = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        #1;
        assert (cpu_ready_o == 1'b1) else begin
            err_cnt++;
            $display("Error at time %0d ns: cpu_ready_o expected 1 got %b",
                     $time, cpu_ready_o);
        end
        assert (cpu_done_o == 1'b0) else begin
            err_cnt++;
            $display("Error at time %0d ns: cpu_done_o expected 0 got %b",
                     $time, cpu_done_o);
        end
        assert (mem_req_o.cmd == MEM_NONE) else begin
            err_cnt++;
            $display("Error at time %0d ns: mem_req_o.cmd expected 0 got %0d",
                     $time, mem_req_o.cmd);
        end

        // the first read misses and the second one hits.
        a_addr = {23'h00_0001, 6'd5, 3'd4};
        mem_log.delete();
        access(1'b0, a_addr, '0, '0);
        assert (mem_log.size() == 1 && mem_log[0].cmd == MEM_REFILL
                && mem_log[0].addr == line_addr(a_addr)) else begin
            err_cnt++;
            $display("a read of a new line did not issue one line-aligned refill");
        end
        mem_log.delete();
        access(1'b0, a_addr, '0, '0);
        assert (lat == 2) else begin
            err_cnt++;
            $display("Error at time %0d ns: cpu_done_o latency expected 2 got %0d", $time, lat);
        end
        assert (mem_log.size() == 0) else begin
            err_cnt++;
            $display("a read hit went out to memory");
        end

        // strobed store hit, then read back.
        access(1'b1, a_addr, 64'h1122_3344_5566_7788, 8'b1010_0101);
        access(1'b0, a_addr, '0, '0);

        // three tags on one set with l1 dirty and l2 touched last.
        l1 = {23'h00_0002, 6'd9, 3'd0};
        l2 = {23'h00_0003, 6'd9, 3'd0};
        l3 = {23'h00_0004, 6'd9, 3'd0};
        access(1'b0, l1, '0, '0);
        access(1'b1, l1, 64'hdead_beef_0bad_f00d, 8'b0000_1111);
        access(1'b0, l2, '0, '0);
        mem_log.delete();
        access(1'b0, l3, '0, '0);
        assert (mem_log.size() == 2 && mem_log[0].cmd == MEM_WRITEBACK
                && mem_log[0].addr == l1 && mem_log[0].wdata == expected_line(l1)
                && mem_log[1].cmd == MEM_REFILL && mem_log[1].addr == l3) else begin
            err_cnt++;
            $display("the dirty victim was not written back with its merged data before the refill");
        end
        access(1'b0, l1, '0, '0);

        // random mix over 4 sets and 4 tags.
        for (int i = 0; i < 300; i++) begin
            rnd  = $random(seed);
            addr = {23'h100 + {21'd0, rnd[1:0]}, 6'd16 + {4'd0, rnd[3:2]}, rnd[6:4]};
            wd   = {$random(seed), $random(seed)};
            access(rnd[7], addr, wd, rnd[15:8]);
        end

        repeat (4) @(posedge clk);
        $display("errors: %0d data checks, %0d protocol assertions",
                 err_cnt, u_dut.u_assert.fail_cnt);
        if (err_cnt == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/dcache_assert.sv
sim/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_dcache \
    -Mdir obj_dir

# assertion failures go on to the closing summary.
out=$(./obj_dir/Vtb_dcache +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
